// ==== hdl/decode_pkg.sv ====
// lane count, address and data widths, opcodes and instruction word union for the decode stage
package decode_pkg;

    localparam int num_lanes  = 2;   // decoder lanes per bundle
    localparam int reg_addr_w = 5;
    localparam int data_w     = 32;
    localparam int num_regs   = 32;  // integer registers, r0 included
    localparam int jump_w     = 8;   // jump target taken from the low bits
    localparam int opcode_w   = 6;

    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [data_w-1:0]     reg_data_t;
    typedef logic [jump_w-1:0]     jump_t;

    typedef enum logic [opcode_w-1:0] {
        RTYPE = 6'd0,
        J     = 6'd2,
        BEQ   = 6'd4,
        ADDI  = 6'd8,
        COP1  = 6'd17,  // adds
        LW    = 6'd35,
        SW    = 6'd43,
        LWC1  = 6'd49,
        SWC1  = 6'd57
    } opcode_t;

    // one instruction word, seen through each encoding format
    typedef union packed {
        struct packed {
            opcode_t    opcode;
            reg_addr_t  rs;
            reg_addr_t  rt;
            reg_addr_t  rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            opcode_t     opcode;
            reg_addr_t   rs;
            reg_addr_t   rt;
            logic [15:0] imm;   // sign extended later
        } i;
        struct packed {
            opcode_t     opcode;
            logic [25:0] target;
        } j;
        struct packed {
            opcode_t    opcode;
            logic [4:0] fmt;    // single or double
            reg_addr_t  ft;
            reg_addr_t  fs;
            reg_addr_t  fd;
            logic [5:0] funct;
        } fr;
    } instr_word_u;

endpackage

// ==== hdl/issue_buffer.sv ====
// issue buffer that latches an instruction bundle and presents per-lane words
`timescale 1ns/1ps

module issue_buffer (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    bundle_valid_i,
    input  decode_pkg::instr_word_u bundle_i [decode_pkg::num_lanes],
    output decode_pkg::instr_word_u lane_word_o [decode_pkg::num_lanes],
    output logic                    lane_valid_o
);

    import decode_pkg::*;

    // valid level follows the strobe by one cycle
    always_ff @(posedge clk) begin
        if (rst_i) begin
            lane_valid_o <= 1'b0;
        end else begin
            lane_valid_o <= bundle_valid_i;
        end
    end

    // words only move on a new bundle
    always_ff @(posedge clk) begin
        if (bundle_valid_i) begin
            for (int l = 0; l < num_lanes; l++) begin
                lane_word_o[l] <= bundle_i[l];  // one word per lane
            end
        end
    end

endmodule

// ==== hdl/instr_decoder.sv ====
// instruction decoder for one lane: integer and float register addresses and jump target
`timescale 1ns/1ps

module instr_decoder (
    input  decode_pkg::instr_word_u word_i,
    output decode_pkg::reg_addr_t   rs_a_o,
    output decode_pkg::reg_addr_t   rt_a_o,
    output decode_pkg::reg_addr_t   rd_a_o,
    output decode_pkg::reg_addr_t   fs_a_o,
    output decode_pkg::reg_addr_t   ft_a_o,
    output decode_pkg::reg_addr_t   fd_a_o,
    output decode_pkg::jump_t       jump_o
);

    import decode_pkg::*;

    opcode_t opcode;

    assign opcode = word_i.r.opcode;  // same field in every view
    assign jump_o = word_i.j.target[jump_w-1:0];  // for any opcode

    // integer register addresses
    always_comb begin
        rs_a_o = '0;
        rt_a_o = '0;
        rd_a_o = '0;
        case (opcode)
            RTYPE: begin  // rd = rs op rt
                rs_a_o = word_i.r.rs;
                rt_a_o = word_i.r.rt;
                rd_a_o = word_i.r.rd;
            end
            ADDI, LW: begin
                rs_a_o = word_i.i.rs;
                rd_a_o = word_i.i.rt;  // rt is the destination here
            end
            BEQ, SW: begin  // compare or store both read
                rs_a_o = word_i.i.rs;
                rt_a_o = word_i.i.rt;
            end
            LWC1, SWC1: begin
                rs_a_o = word_i.i.rs;  // base address only
            end
            default: begin
                // J and unknown opcodes touch no integer register
                rs_a_o = '0;
            end
        endcase
    end

    // float register addresses
    always_comb begin
        fs_a_o = '0;
        ft_a_o = '0;
        fd_a_o = '0;
        case (opcode)
            LWC1: begin
                fd_a_o = word_i.i.rt;  // load target
            end
            SWC1: begin
                ft_a_o = word_i.i.rt;  // store source
            end
            COP1: begin  // adds fd = fs + ft
                fs_a_o = word_i.fr.fs;
                ft_a_o = word_i.fr.ft;
                fd_a_o = word_i.fr.fd;
            end
            default: begin
                fd_a_o = '0;
            end
        endcase
    end

endmodule

// ==== hdl/operand_file.sv ====
// integer register file with write bypass and registered per-lane decode results
`timescale 1ns/1ps

module operand_file (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  lane_valid_i,
    input  logic                  wr_en_i,
    input  decode_pkg::reg_addr_t wr_addr_i,
    input  decode_pkg::reg_data_t wr_data_i,
    input  decode_pkg::reg_addr_t rs_a_i [decode_pkg::num_lanes],
    input  decode_pkg::reg_addr_t rt_a_i [decode_pkg::num_lanes],
    input  decode_pkg::reg_addr_t rd_a_i [decode_pkg::num_lanes],
    input  decode_pkg::reg_addr_t fs_a_i [decode_pkg::num_lanes],
    input  decode_pkg::reg_addr_t ft_a_i [decode_pkg::num_lanes],
    input  decode_pkg::reg_addr_t fd_a_i [decode_pkg::num_lanes],
    input  decode_pkg::jump_t     jump_i [decode_pkg::num_lanes],
    output decode_pkg::reg_addr_t rs_a_o [decode_pkg::num_lanes],
    output decode_pkg::reg_addr_t rt_a_o [decode_pkg::num_lanes],
    output decode_pkg::reg_addr_t rd_a_o [decode_pkg::num_lanes],
    output decode_pkg::reg_addr_t fs_a_o [decode_pkg::num_lanes],
    output decode_pkg::reg_addr_t ft_a_o [decode_pkg::num_lanes],
    output decode_pkg::reg_addr_t fd_a_o [decode_pkg::num_lanes],
    output decode_pkg::jump_t     jump_o [decode_pkg::num_lanes],
    output decode_pkg::reg_data_t rs_d_o [decode_pkg::num_lanes],
    output decode_pkg::reg_data_t rt_d_o [decode_pkg::num_lanes],
    output logic                  out_valid_o
);

    import decode_pkg::*;

    reg_data_t regs [num_regs];  // r0 is writable
    reg_data_t rs_d [num_lanes];
    reg_data_t rt_d [num_lanes];

    // two read ports per lane, write data wins on an address match
    always_comb begin
        for (int l = 0; l < num_lanes; l++) begin
            if (wr_en_i && (wr_addr_i == rs_a_i[l])) begin
                rs_d[l] = wr_data_i;  // bypass
            end else begin
                rs_d[l] = regs[rs_a_i[l]];
            end
            if (wr_en_i && (wr_addr_i == rt_a_i[l])) begin
                rt_d[l] = wr_data_i;
            end else begin
                rt_d[l] = regs[rt_a_i[l]];
            end
        end
    end

    // write-back port
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int r = 0; r < num_regs; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_en_i) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= lane_valid_i;  // one cycle pulse per bundle
        end
    end

    // results held while no lane is valid
    always_ff @(posedge clk) begin
        if (lane_valid_i) begin
            for (int l = 0; l < num_lanes; l++) begin
                rs_a_o[l] <= rs_a_i[l];
                rt_a_o[l] <= rt_a_i[l];
                rd_a_o[l] <= rd_a_i[l];
                fs_a_o[l] <= fs_a_i[l];
                ft_a_o[l] <= ft_a_i[l];
                fd_a_o[l] <= fd_a_i[l];
                jump_o[l] <= jump_i[l];
                rs_d_o[l] <= rs_d[l];
                rt_d_o[l] <= rt_d[l];
            end
        end
    end

endmodule

// ==== hdl/decode_stage.sv ====
// two-lane decode stage top level: issue buffer, lane decoders and operand file
`timescale 1ns/1ps

module decode_stage (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    bundle_valid_i,
    input  decode_pkg::instr_word_u bundle_i [decode_pkg::num_lanes],
    input  logic                    wr_en_i,
    input  decode_pkg::reg_addr_t   wr_addr_i,
    input  decode_pkg::reg_data_t   wr_data_i,
    output decode_pkg::reg_addr_t   rs_a_o [decode_pkg::num_lanes],
    output decode_pkg::reg_addr_t   rt_a_o [decode_pkg::num_lanes],
    output decode_pkg::reg_addr_t   rd_a_o [decode_pkg::num_lanes],
    output decode_pkg::reg_addr_t   fs_a_o [decode_pkg::num_lanes],
    output decode_pkg::reg_addr_t   ft_a_o [decode_pkg::num_lanes],
    output decode_pkg::reg_addr_t   fd_a_o [decode_pkg::num_lanes],
    output decode_pkg::jump_t       jump_o [decode_pkg::num_lanes],
    output decode_pkg::reg_data_t   rs_d_o [decode_pkg::num_lanes],
    output decode_pkg::reg_data_t   rt_d_o [decode_pkg::num_lanes],
    output logic                    out_valid_o
);

    import decode_pkg::*;

    instr_word_u lane_word [num_lanes];
    logic        lane_valid;
    reg_addr_t   rs_a [num_lanes];
    reg_addr_t   rt_a [num_lanes];
    reg_addr_t   rd_a [num_lanes];
    reg_addr_t   fs_a [num_lanes];
    reg_addr_t   ft_a [num_lanes];
    reg_addr_t   fd_a [num_lanes];
    jump_t       jump [num_lanes];

    issue_buffer u_issue (
        .clk            (clk),
        .rst_i          (rst_i),
        .bundle_valid_i (bundle_valid_i),
        .bundle_i       (bundle_i),
        .lane_word_o    (lane_word),
        .lane_valid_o   (lane_valid)
    );

    for (genvar l = 0; l < num_lanes; l++) begin : g_lane
        instr_decoder u_dec (
            .word_i (lane_word[l]),
            .rs_a_o (rs_a[l]),
            .rt_a_o (rt_a[l]),
            .rd_a_o (rd_a[l]),
            .fs_a_o (fs_a[l]),
            .ft_a_o (ft_a[l]),
            .fd_a_o (fd_a[l]),
            .jump_o (jump[l])
        );
    end

    operand_file u_opf (
        .clk          (clk),
        .rst_i        (rst_i),
        .lane_valid_i (lane_valid),
        .wr_en_i      (wr_en_i),
        .wr_addr_i    (wr_addr_i),
        .wr_data_i    (wr_data_i),
        .rs_a_i       (rs_a),
        .rt_a_i       (rt_a),
        .rd_a_i       (rd_a),
        .fs_a_i       (fs_a),
        .ft_a_i       (ft_a),
        .fd_a_i       (fd_a),
        .jump_i       (jump),
        .rs_a_o       (rs_a_o),
        .rt_a_o       (rt_a_o),
        .rd_a_o       (rd_a_o),
        .fs_a_o       (fs_a_o),
        .ft_a_o       (ft_a_o),
        .fd_a_o       (fd_a_o),
        .jump_o       (jump_o),
        .rs_d_o       (rs_d_o),
        .rt_d_o       (rt_d_o),
        .out_valid_o  (out_valid_o)
    );

endmodule

// ==== verification/decode_stage_tb.sv ====
// testbench for the two-lane decode stage: pattern file stimulus, register model and result checks
`timescale 1ns/1ps

module decode_stage_tb;

    import decode_pkg::*;

    localparam int max_tests  = 64;
    localparam int num_fields = 17;  // en, addr, data, two words, six addresses per lane

    // expected results of one bundle
    typedef struct packed {
        int unsigned                    idx;
        int unsigned                    due;   // cycle with out_valid_o high
        reg_addr_t [num_lanes-1:0][5:0] addr;  // rs rt rd fs ft fd
        jump_t     [num_lanes-1:0]      jump;
        reg_data_t [num_lanes-1:0]      rs_d;
        reg_data_t [num_lanes-1:0]      rt_d;
    } expect_t;

    logic        clk;
    logic        rst_i;
    logic        bundle_valid_i;
    instr_word_u bundle_i [num_lanes];
    logic        wr_en_i;
    reg_addr_t   wr_addr_i;
    reg_data_t   wr_data_i;
    reg_addr_t   rs_a_o [num_lanes];
    reg_addr_t   rt_a_o [num_lanes];
    reg_addr_t   rd_a_o [num_lanes];
    reg_addr_t   fs_a_o [num_lanes];
    reg_addr_t   ft_a_o [num_lanes];
    reg_addr_t   fd_a_o [num_lanes];
    jump_t       jump_o [num_lanes];
    reg_data_t   rs_d_o [num_lanes];
    reg_data_t   rt_d_o [num_lanes];
    logic        out_valid_o;

    logic [31:0] pat [max_tests][num_fields];
    reg_data_t   model [num_regs];  // reference copy of the register file
    expect_t     exp_q [$];
    int          n_tests;
    int unsigned cyc;
    int          test_errs;
    int          pass_cnt;
    int          fail_cnt;
    int          seed;
    bit          loaded;

    decode_stage UUT (
        .clk            (clk),
        .rst_i          (rst_i),
        .bundle_valid_i (bundle_valid_i),
        .bundle_i       (bundle_i),
        .wr_en_i        (wr_en_i),
        .wr_addr_i      (wr_addr_i),
        .wr_data_i      (wr_data_i),
        .rs_a_o         (rs_a_o),
        .rt_a_o         (rt_a_o),
        .rd_a_o         (rd_a_o),
        .fs_a_o         (fs_a_o),
        .ft_a_o         (ft_a_o),
        .fd_a_o         (fd_a_o),
        .jump_o         (jump_o),
        .rs_d_o         (rs_d_o),
        .rt_d_o         (rt_d_o),
        .out_valid_o    (out_valid_o)
    );

    always #20 clk = ~clk;  // 40 ns period

    task automatic check_addr(input string what, input reg_addr_t got, input reg_addr_t want);
        if (got !== want) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, want);
            test_errs++;
        end
    endtask

    task automatic check_data(input string what, input reg_data_t got, input reg_data_t want);
        if (got !== want) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, want);
            test_errs++;
        end
    endtask

    task automatic check_jump(input string what, input jump_t got, input jump_t want);
        if (got !== want) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, want);
            test_errs++;
        end
    endtask

    // one test per line, lines starting with # are skipped
    task automatic read_patterns(output int count);
        int          fd;
        int          code;
        string       line;
        logic [31:0] f [num_fields];
        count = 0;
        fd = $fopen("verification/decode_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file");
        end else begin
            while (!$feof(fd) && count < max_tests) begin
                code = $fgets(line, fd);
                if (code > 1 && line.getc(0) != "#") begin
                    code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                   f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                                   f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
                    if (code == num_fields) begin
                        for (int i = 0; i < num_fields; i++) begin
                            pat[count][i] = f[i];
                        end
                        count++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic report_test(input int unsigned idx);
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %0d passed", idx);
        end else begin
            fail_cnt++;
            $display("test %0d failed with %0d errors", idx, test_errs);
        end
    endtask

    task automatic compare_lanes(input expect_t e);
        string tag;
        for (int l = 0; l < num_lanes; l++) begin
            tag = $sformatf("test %0d lane %0d", e.idx, l);
            check_addr({tag, " rs_a"}, rs_a_o[l], e.addr[l][0]);
            check_addr({tag, " rt_a"}, rt_a_o[l], e.addr[l][1]);
            check_addr({tag, " rd_a"}, rd_a_o[l], e.addr[l][2]);
            check_addr({tag, " fs_a"}, fs_a_o[l], e.addr[l][3]);
            check_addr({tag, " ft_a"}, ft_a_o[l], e.addr[l][4]);
            check_addr({tag, " fd_a"}, fd_a_o[l], e.addr[l][5]);
            check_jump({tag, " jump"}, jump_o[l], e.jump[l]);
            check_data({tag, " rs_d"}, rs_d_o[l], e.rs_d[l]);
            check_data({tag, " rt_d"}, rt_d_o[l], e.rt_d[l]);
        end
    endtask

    task automatic check_outputs();
        expect_t e;
        if (out_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("out_valid_o high at %0t ns with no bundle in flight", $time);
                fail_cnt++;
            end else begin
                e = exp_q.pop_front();
                test_errs = 0;
                if (e.due != cyc) begin
                    $display("test %0d came out in cycle %0d instead of %0d", e.idx, cyc, e.due);
                    test_errs++;
                end
                compare_lanes(e);
                report_test(e.idx);
            end
        end else if (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
            e = exp_q.pop_front();
            $display("out_valid_o never rose for test %0d", e.idx);
            test_errs = 1;
            report_test(e.idx);
        end
    endtask

    // outputs are looked at on the falling edge, before new inputs go out
    task automatic step();
        @(negedge clk);
        cyc++;
        check_outputs();
    endtask

    task automatic drive_write(input int k);
        if (k < 0 || k >= n_tests) begin
            wr_en_i = 1'b0;
        end else begin
            wr_en_i   = pat[k][0][0];
            wr_addr_i = pat[k][1][4:0];
            wr_data_i = pat[k][2];
        end
    endtask

    // bundle k goes out with the write-back of test k-1
    task automatic issue_test(input int k);
        expect_t e;
        bundle_valid_i = 1'b1;
        for (int l = 0; l < num_lanes; l++) begin
            bundle_i[l] = pat[k][3 + l];
        end
        drive_write(k - 1);
        e.idx = k;
        e.due = cyc + 2;
        // write k lands on the edge that registers bundle k, so its data is bypassed
        if (pat[k][0][0]) begin
            model[pat[k][1][4:0]] = pat[k][2];
        end
        for (int l = 0; l < num_lanes; l++) begin
            for (int a = 0; a < 6; a++) begin
                e.addr[l][a] = pat[k][5 + 6 * l + a][4:0];
            end
            e.jump[l] = pat[k][3 + l][7:0];  // low byte of the word
            e.rs_d[l] = model[e.addr[l][0]];
            e.rt_d[l] = model[e.addr[l][1]];
        end
        exp_q.push_back(e);
    endtask

    initial begin
        clk            = 1'b0;
        rst_i          = 1'b1;
        bundle_valid_i = 1'b0;
        wr_en_i        = 1'b0;
        wr_addr_i      = '0;
        wr_data_i      = '0;
        for (int l = 0; l < num_lanes; l++) begin
            bundle_i[l] = '0;
        end
        for (int r = 0; r < num_regs; r++) begin
            model[r] = '0;
        end
        cyc       = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        test_errs = 0;
        seed      = 32'h3210f9a0;
        read_patterns(n_tests);
        loaded = 1'b1;
        if (n_tests == 0) begin
            $display("no test patterns could be read");
            $display("TEST FAIL");
            $finish;
        end else begin
            repeat (3) step();
            rst_i = 1'b0;
            for (int r = 0; r < num_regs; r++) begin  // random preload of every register
                wr_en_i   = 1'b1;
                wr_addr_i = reg_addr_t'(r);
                wr_data_i = $random(seed);
                model[r]  = wr_data_i;
                step();
            end
            for (int k = 0; k < n_tests; k++) begin
                issue_test(k);
                step();
            end
            bundle_valid_i = 1'b0;
            drive_write(n_tests - 1);
            step();
            drive_write(n_tests);
            while (exp_q.size() != 0) begin
                step();
            end
            step();  // catches a late extra out_valid_o
            $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
            if (fail_cnt == 0) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
            $finish;
        end
    end

    // watchdog sized from reset, preload and pattern count
    initial begin
        wait (loaded);
        repeat (n_tests + num_regs + 16) #40;
        $display("timeout: the run did not finish in %0d cycles", n_tests + num_regs + 16);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== verification/decode_patterns.txt ====
# wr_en wr_addr wr_data word0 word1, then lane 0 rs rt rd fs ft fd, then lane 1 rs rt rd fs ft fd
# all values hex, the write of a line is issued together with that line's operand read
0 00 00000000 00221820 20850010 01 02 03 00 00 00 04 00 05 00 00 00
1 06 12345678 8cc70004 1109fffe 06 00 07 00 00 00 08 09 00 00 00 00
1 0d a5a5a5a5 ad4b0008 018d7022 0a 0b 00 00 00 00 0c 0d 0e 00 00 00
1 10 0badf00d c5e40020 e6060024 0f 00 00 00 00 04 10 00 00 00 06 00
1 00 ffff0000 46030880 080000a5 00 00 00 01 03 02 00 00 00 00 00 00
1 15 cafe0001 22327fff 8e740100 11 00 12 00 00 00 13 00 14 00 00 00
1 16 5a5a0016 12b60003 aed500c0 15 16 00 00 00 00 16 15 00 00 00 00
0 00 deadbeef 0bffffff 461df7c0 00 00 00 00 00 00 00 00 00 1e 1d 1f
1 1f 0000ffff 03e00825 c45f0ff0 1f 00 01 00 00 00 02 00 00 00 00 1f
1 05 80000005 e4600000 00a7482a 03 00 00 00 00 00 05 07 09 00 00 00

// ==== decode_stage.f ====
hdl/decode_pkg.sv
hdl/issue_buffer.sv
hdl/instr_decoder.sv
hdl/operand_file.sv
hdl/decode_stage.sv
verification/decode_stage_tb.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --timing
TOP      := decode_stage_tb
RTL_TOP  := decode_stage
FILELIST := decode_stage.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
